//--- Makefile
SOURCES := $(shell grep -v '^+' ioManager.f)

.PHONY: all run clean

all: obj_dir/VioManagerTb

obj_dir/VioManagerTb: ioManager.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f ioManager.f \
		--top-module ioManagerTb -o VioManagerTb

run: obj_dir/VioManagerTb
	./obj_dir/VioManagerTb | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/ioManagerTb.sv
`timescale 1ns/1ps

module ioManagerTb;

    typedef struct packed {
        logic [15:0] addr;
        logic [3:0]  op;
        logic [15:0] data;
        logic [3:0]  dest;
        logic        drain;   // Wait for all earlier writebacks first
        logic        expPost;
        logic [15:0] expData;
    } entryT;

    localparam int stallEntry = 15; // Second start of the four-timer run
    localparam int quietCycles = 300;

    logic sys_clk;
    logic rstN;
    logic cmdAck;
    logic cmdReq;
    logic [3:0] minorOpcodeIn;
    logic [15:0] cmdAddressIn;
    logic [15:0] cmdDataIn;
    logic [3:0] cmdDestReg;
    logic wbAck;
    logic wbReq;
    logic [3:0] wbDestReg;
    logic [15:0] wbDataOut;

    entryT stimTable[$];
    logic [19:0] expQ[$]; // {destReg, data}
    int errors = 0;
    int wbCount = 0;
    int stallCycles = 0;

    ioManager ioManager_i (
        .sys_clk      (sys_clk),
        .rstN         (rstN),
        .cmdAck       (cmdAck),
        .cmdReq       (cmdReq),
        .minorOpcodeIn(minorOpcodeIn),
        .cmdAddressIn (cmdAddressIn),
        .cmdDataIn    (cmdDataIn),
        .cmdDestReg   (cmdDestReg),
        .wbAck        (wbAck),
        .wbReq        (wbReq),
        .wbDestReg    (wbDestReg),
        .wbDataOut    (wbDataOut)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    function automatic logic [15:0] timerAddr(input int idx);
        return ioMapPkg::ioBaseAddr + ioMapPkg::timerLowerAddr + 16'(idx);
    endfunction

    task automatic addEntry(input logic [15:0] addr, input logic [3:0] op,
                            input logic [15:0] data, input logic [3:0] dest,
                            input logic drain, input logic expPost,
                            input logic [15:0] expData);
        entryT e;
        e = '{addr, op, data, dest, drain, expPost, expData};
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        // Reload values read back per timer
        addEntry(timerAddr(0), ioCmdPkg::opLoad, 16'h1111, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(1), ioCmdPkg::opLoad, 16'h2222, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(2), ioCmdPkg::opLoad, 16'h3333, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(3), ioCmdPkg::opLoad, 16'h4444, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(0), ioCmdPkg::opReadLoad, 16'h0, 4'd1, 0, 1, 16'h1111);
        addEntry(timerAddr(1), ioCmdPkg::opReadLoad, 16'h0, 4'd2, 0, 1, 16'h2222);
        addEntry(timerAddr(2), ioCmdPkg::opReadLoad, 16'h0, 4'd3, 0, 1, 16'h3333);
        addEntry(timerAddr(3), ioCmdPkg::opReadLoad, 16'h0, 4'd4, 0, 1, 16'h4444);
        // Expiry count goes up by one per run
        addEntry(timerAddr(0), ioCmdPkg::opLoad, 16'd5, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(0), ioCmdPkg::opStart, 16'h0, 4'd7, 0, 1, 16'd1);
        addEntry(timerAddr(0), ioCmdPkg::opStart, 16'h0, 4'd8, 1, 1, 16'd2);
        // All four running at once
        addEntry(timerAddr(1), ioCmdPkg::opLoad, 16'd7, 4'd0, 1, 0, 16'h0);
        addEntry(timerAddr(2), ioCmdPkg::opLoad, 16'd3, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(3), ioCmdPkg::opLoad, 16'd9, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(0), ioCmdPkg::opStart, 16'h0, 4'd11, 0, 1, 16'd3);
        addEntry(timerAddr(1), ioCmdPkg::opStart, 16'h0, 4'd12, 0, 1, 16'd1);
        addEntry(timerAddr(2), ioCmdPkg::opStart, 16'h0, 4'd13, 0, 1, 16'd1);
        addEntry(timerAddr(3), ioCmdPkg::opStart, 16'h0, 4'd14, 0, 1, 16'd1);
        // Timer 1 stopped long before its expiry
        addEntry(timerAddr(1), ioCmdPkg::opLoad, 16'd200, 4'd0, 1, 0, 16'h0);
        addEntry(timerAddr(2), ioCmdPkg::opLoad, 16'd30, 4'd0, 0, 0, 16'h0);
        addEntry(timerAddr(1), ioCmdPkg::opStart, 16'h0, 4'd5, 0, 0, 16'h0);
        addEntry(timerAddr(2), ioCmdPkg::opStart, 16'h0, 4'd6, 0, 1, 16'd2);
        addEntry(timerAddr(1), ioCmdPkg::opStop, 16'h0, 4'd0, 0, 0, 16'h0);
        // Dropped commands
        addEntry(ioMapPkg::ioBaseAddr, ioCmdPkg::opReadLoad, 16'h0, 4'd9, 0, 0, 16'h0);
        addEntry(ioMapPkg::ioBaseAddr + 16'd12, ioCmdPkg::opReadLoad, 16'h0, 4'd10, 0, 0, 16'h0);
        addEntry(ioMapPkg::ioBaseAddr + 16'd100, ioCmdPkg::opReadLoad, 16'h0, 4'd15, 0, 0, 16'h0);
        addEntry(timerAddr(3), 4'd9, 16'h0, 4'd15, 0, 0, 16'h0); // Unused opcode
    endtask

    task automatic issueCommand(input int idx);
        entryT e;
        e = stimTable[idx];
        if (e.drain) begin
            @(negedge sys_clk);
            cmdAck = 1'b0;
            while (expQ.size() != 0) @(negedge sys_clk);
        end
        @(negedge sys_clk);
        cmdAddressIn = e.addr;
        minorOpcodeIn = e.op;
        cmdDataIn = e.data;
        cmdDestReg = e.dest;
        cmdAck = 1'b1;
        @(posedge sys_clk);
        while (!cmdReq) @(posedge sys_clk);
        if (e.expPost) expQ.push_back({e.dest, e.expData});
        if (idx == stallEntry) stallCycles = 20;
    endtask

    // Matched by value, so arrival order is free
    task automatic checkWriteback(input logic [3:0] dest, input logic [15:0] data);
        int hit;
        hit = -1;
        foreach (expQ[k]) begin
            if (hit < 0 && expQ[k] == {dest, data}) hit = k;
        end
        if (hit < 0) begin
            errors++;
            $display("ERROR at %0t ns: unexpected writeback reg %0d data %h", $time, dest, data);
        end else begin
            expQ.delete(hit);
        end
    endtask

    always @(posedge sys_clk) begin
        if (rstN && wbAck && wbReq) begin
            wbCount++;
            checkWriteback(wbDestReg, wbDataOut);
        end
    end

    initial begin
        void'($urandom(32'hb9e28e3f));
        forever begin
            @(negedge sys_clk);
            if (stallCycles > 0) begin
                wbReq = 1'b0;
                stallCycles--;
            end else begin
                wbReq = ($urandom % 10) >= 3; // Low about 30% of cycles
            end
        end
    end

    initial begin
        @(posedge rstN);
        repeat (stimTable.size() * 300) @(posedge sys_clk);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 stimTable.size() * 300);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        cmdAck = 1'b0;
        minorOpcodeIn = '0;
        cmdAddressIn = '0;
        cmdDataIn = '0;
        cmdDestReg = '0;
        wbReq = 1'b0;
        buildTable();
        repeat (8) @(negedge sys_clk);
        rstN = 1'b1;
        if (cmdReq !== 1'b1 || wbAck !== 1'b0) begin
            errors++;
            $display("ERROR at %0t ns: after reset cmdReq %b wbAck %b", $time, cmdReq, wbAck);
        end
        for (int i = 0; i < stimTable.size(); i++) issueCommand(i);
        @(negedge sys_clk);
        cmdAck = 1'b0;
        while (expQ.size() != 0) @(negedge sys_clk);
        repeat (quietCycles) @(posedge sys_clk); // Time for any stray post
        $display("Summary: %0d writebacks, %0d errors, %0d pending",
                 wbCount, errors, expQ.size());
        if (errors == 0 && expQ.size() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- ioManager.f
rtl/ioMapPkg.sv
rtl/ioCmdPkg.sv
rtl/cmdDecoder.sv
rtl/cmdTimer.sv
rtl/writebackMux.sv
rtl/ioManager.sv
dv/ioManagerTb.sv

//--- rtl/cmdDecoder.sv
`timescale 1ns/1ps

module cmdDecoder (
    input  logic                            sys_clk,
    input  logic                            rstN,
    input  logic                            cmdAck,
    output logic                            cmdReq,
    input  ioCmdPkg::opcodeT                minorOpcodeIn,
    input  ioMapPkg::ioAddrT                cmdAddressIn,
    input  ioCmdPkg::dataT                  cmdDataIn,
    input  ioCmdPkg::regIdxT                cmdDestReg,
    input  logic [ioMapPkg::timerCount-1:0] timerReady,
    output logic [ioMapPkg::timerCount-1:0] selStrobe,
    output ioCmdPkg::opcodeT                selOpcode,
    output ioCmdPkg::dataT                  selData,
    output ioCmdPkg::regIdxT                selDestReg
);
    ioMapPkg::ioAddrT windowOffset;
    ioMapPkg::ioAddrT timerOffset;
    logic mapped;
    logic [ioMapPkg::timerCount-1:0] decodedSel;
    logic [ioMapPkg::timerCount-1:0] selReg;
    logic full;
    logic drain;

    assign windowOffset = cmdAddressIn - ioMapPkg::ioBaseAddr;
    assign timerOffset = windowOffset - ioMapPkg::timerLowerAddr;
    // Wraparound pushes addresses below the window out of range
    assign mapped = (windowOffset < ioMapPkg::ioWindowSize) &&
                    (timerOffset < ioMapPkg::timerCount);

    always_comb begin
        decodedSel = '0;
        if (mapped) decodedSel[ioMapPkg::timerIdxT'(timerOffset)] = 1'b1;
    end

    // Empty select means unmapped and is dropped on the next edge
    assign drain = full && ((selReg == '0) || ((selReg & timerReady) != '0));
    assign selStrobe = full ? (selReg & timerReady) : '0;
    assign cmdReq = !full || drain;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
            selReg <= '0;
        end else if (cmdAck && cmdReq) begin
            full <= 1'b1;
            selReg <= decodedSel;
        end else if (drain) begin
            full <= 1'b0;
            selReg <= '0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (cmdAck && cmdReq) begin
            selOpcode <= minorOpcodeIn;
            selData <= cmdDataIn;
            selDestReg <= cmdDestReg;
        end
    end

    selOneHot: assert property (@(posedge sys_clk) disable iff (!rstN) $onehot0(selStrobe));

endmodule

//--- rtl/cmdTimer.sv
`timescale 1ns/1ps

module cmdTimer (
    input  logic             sys_clk,
    input  logic             rstN,
    input  logic             selStrobe,
    input  ioCmdPkg::opcodeT selOpcode,
    input  ioCmdPkg::dataT   selData,
    input  ioCmdPkg::regIdxT selDestReg,
    output logic             timerReady,
    output logic             postValid,
    output ioCmdPkg::regIdxT postDestReg,
    output ioCmdPkg::dataT   postData,
    input  logic             postTaken
);
    ioCmdPkg::timerStateE state;
    ioCmdPkg::dataT reloadReg;
    ioCmdPkg::dataT countReg;
    ioCmdPkg::dataT expiryReg;
    ioCmdPkg::dataT expiryNext;
    ioCmdPkg::regIdxT destLatch;
    logic cmdLoad;
    logic cmdStart;
    logic cmdStop;
    logic cmdRead;
    logic holdFree;
    logic expire;

    assign cmdLoad = selStrobe && (selOpcode == ioCmdPkg::opLoad);
    assign cmdStart = selStrobe && (selOpcode == ioCmdPkg::opStart);
    assign cmdStop = selStrobe && (selOpcode == ioCmdPkg::opStop);
    assign cmdRead = selStrobe && (selOpcode == ioCmdPkg::opReadLoad);

    // Stall the decoder only for commands that need the holding register
    assign timerReady = !(postValid && ((selOpcode == ioCmdPkg::opReadLoad) ||
                          (selOpcode == ioCmdPkg::opStart && state == ioCmdPkg::tPosting)));

    assign holdFree = !postValid || postTaken;
    assign expiryNext = expiryReg + 1'b1;

    // Counter parks at zero until the holding register frees up
    assign expire = (state == ioCmdPkg::tRunning) && (countReg == '0) && holdFree &&
                    !cmdRead && !cmdStart && !cmdStop;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            state <= ioCmdPkg::tIdle;
            reloadReg <= '0;
            countReg <= '0;
            expiryReg <= '0;
        end else begin
            if (cmdLoad) reloadReg <= selData;
            if (cmdStart) begin
                state <= ioCmdPkg::tRunning;
                countReg <= reloadReg;
            end else if (cmdStop) begin
                state <= ioCmdPkg::tIdle;
            end else if (expire) begin
                state <= ioCmdPkg::tPosting;
                expiryReg <= expiryNext;
            end else if (state == ioCmdPkg::tRunning && countReg != '0) begin
                countReg <= countReg - 1'b1;
            end else if (state == ioCmdPkg::tPosting && postTaken) begin
                state <= ioCmdPkg::tIdle;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (cmdStart) destLatch <= selDestReg;
    end

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) postValid <= 1'b0;
        else if (cmdRead || expire) postValid <= 1'b1;
        else if (postTaken) postValid <= 1'b0;
    end

    always_ff @(posedge sys_clk) begin
        if (cmdRead) begin
            postDestReg <= selDestReg;
            postData <= reloadReg;
        end else if (expire) begin
            postDestReg <= destLatch; // Destination from the last opStart
            postData <= expiryNext;
        end
    end

    postHeld: assert property (@(posedge sys_clk) disable iff (!rstN)
        postValid && !postTaken |=> postValid && $stable(postData) && $stable(postDestReg));

    strobeWhenReady: assert property (@(posedge sys_clk) disable iff (!rstN)
        selStrobe |-> timerReady);

    postingHasEntry: assert property (@(posedge sys_clk) disable iff (!rstN)
        state == ioCmdPkg::tPosting |-> postValid);

endmodule

//--- rtl/ioCmdPkg.sv
package ioCmdPkg;

    localparam int dataWidth = 16;
    localparam int regIdxWidth = 4;
    localparam int opcodeWidth = 4;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [regIdxWidth-1:0] regIdxT;
    typedef logic [opcodeWidth-1:0] opcodeT;

    // Minor opcodes a timer acts on
    localparam opcodeT opLoad = 4'd0;
    localparam opcodeT opStart = 4'd1;
    localparam opcodeT opStop = 4'd2;
    localparam opcodeT opReadLoad = 4'd3;

    typedef enum logic [1:0] {
        tIdle,
        tRunning,
        tPosting // Expiry count waiting in the holding register
    } timerStateE;

endpackage

//--- rtl/ioManager.sv
`timescale 1ns/1ps

module ioManager (
    input  logic             sys_clk,
    input  logic             rstN,
    input  logic             cmdAck,
    output logic             cmdReq,
    input  ioCmdPkg::opcodeT minorOpcodeIn,
    input  ioMapPkg::ioAddrT cmdAddressIn,
    input  ioCmdPkg::dataT   cmdDataIn,
    input  ioCmdPkg::regIdxT cmdDestReg,
    output logic             wbAck,
    input  logic             wbReq,
    output ioCmdPkg::regIdxT wbDestReg,
    output ioCmdPkg::dataT   wbDataOut
);
    logic [ioMapPkg::timerCount-1:0] selStrobe;
    logic [ioMapPkg::timerCount-1:0] timerReady;
    ioCmdPkg::opcodeT selOpcode;
    ioCmdPkg::dataT selData;
    ioCmdPkg::regIdxT selDestReg;

    logic [ioMapPkg::timerCount-1:0] postValid;
    logic [ioMapPkg::timerCount-1:0] postTaken;
    ioCmdPkg::regIdxT [ioMapPkg::timerCount-1:0] postDestReg;
    ioCmdPkg::dataT [ioMapPkg::timerCount-1:0] postData;

    cmdDecoder cmdDecoder_i (
        .sys_clk      (sys_clk),
        .rstN         (rstN),
        .cmdAck       (cmdAck),
        .cmdReq       (cmdReq),
        .minorOpcodeIn(minorOpcodeIn),
        .cmdAddressIn (cmdAddressIn),
        .cmdDataIn    (cmdDataIn),
        .cmdDestReg   (cmdDestReg),
        .timerReady   (timerReady),
        .selStrobe    (selStrobe),
        .selOpcode    (selOpcode),
        .selData      (selData),
        .selDestReg   (selDestReg)
    );

    // Shared command lines and one strobe per timer
    for (genvar i = 0; i < ioMapPkg::timerCount; i++) begin : timerGen
        cmdTimer cmdTimer_i (
            .sys_clk    (sys_clk),
            .rstN       (rstN),
            .selStrobe  (selStrobe[i]),
            .selOpcode  (selOpcode),
            .selData    (selData),
            .selDestReg (selDestReg),
            .timerReady (timerReady[i]),
            .postValid  (postValid[i]),
            .postDestReg(postDestReg[i]),
            .postData   (postData[i]),
            .postTaken  (postTaken[i])
        );
    end

    writebackMux writebackMux_i (
        .sys_clk    (sys_clk),
        .rstN       (rstN),
        .postValid  (postValid),
        .postDestReg(postDestReg),
        .postData   (postData),
        .postTaken  (postTaken),
        .wbAck      (wbAck),
        .wbReq      (wbReq),
        .wbDestReg  (wbDestReg),
        .wbDataOut  (wbDataOut)
    );

endmodule

//--- rtl/ioMapPkg.sv
package ioMapPkg;

    // Command address as seen on the IO window
    typedef logic [15:0] ioAddrT;

    localparam ioAddrT ioBaseAddr = 16'd384;
    localparam ioAddrT ioWindowSize = 16'd128;

    // Timers sit after the clock block
    localparam ioAddrT timerLowerAddr = 16'd8;

    localparam int timerCount = 4; // Power of two
    localparam int timerIdxWidth = $clog2(timerCount);

    typedef logic [timerIdxWidth-1:0] timerIdxT;

endpackage

//--- rtl/writebackMux.sv
`timescale 1ns/1ps

module writebackMux (
    input  logic                                      sys_clk,
    input  logic                                      rstN,
    input  logic [ioMapPkg::timerCount-1:0]           postValid,
    input  ioCmdPkg::regIdxT [ioMapPkg::timerCount-1:0] postDestReg,
    input  ioCmdPkg::dataT [ioMapPkg::timerCount-1:0] postData,
    output logic [ioMapPkg::timerCount-1:0]           postTaken,
    output logic                                      wbAck,
    input  logic                                      wbReq,
    output ioCmdPkg::regIdxT                          wbDestReg,
    output ioCmdPkg::dataT                            wbDataOut
);
    ioMapPkg::timerIdxT lastGrant;
    ioMapPkg::timerIdxT grantIdx;
    logic found;
    logic outFree;
    logic take;

    // Empty or handing off this edge
    assign outFree = !wbAck || wbReq;

    // Search starts just after the last winner
    always_comb begin
        ioMapPkg::timerIdxT cand;
        found = 1'b0;
        grantIdx = lastGrant;
        for (int k = 1; k <= ioMapPkg::timerCount; k++) begin
            cand = ioMapPkg::timerIdxT'(lastGrant + k);
            if (!found && postValid[cand]) begin
                found = 1'b1;
                grantIdx = cand;
            end
        end
    end

    assign take = outFree && found;

    always_comb begin
        postTaken = '0;
        if (take) postTaken[grantIdx] = 1'b1;
    end

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            wbAck <= 1'b0;
            lastGrant <= ioMapPkg::timerIdxT'(ioMapPkg::timerCount - 1); // Timer 0 first
        end else if (take) begin
            wbAck <= 1'b1;
            lastGrant <= grantIdx;
        end else if (wbReq) begin
            wbAck <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            wbDestReg <= postDestReg[grantIdx];
            wbDataOut <= postData[grantIdx];
        end
    end

    takenOneHot: assert property (@(posedge sys_clk) disable iff (!rstN) $onehot0(postTaken));

endmodule
